/* vlog.f */
verilog/aluPkg.sv
verilog/bitSlice.sv
verilog/aluCore.sv
verilog/opQueue.sv
verilog/resultSender.sv
verilog/aluUnit.sv
sim/aluUnit_assert.sv
sim/aluChecker.sv
sim/aluTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f vlog.f --top-module aluTb -o aluSim

# the log decides the outcome, so the simulator status is not used here
./obj_dir/aluSim | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* sim/aluTb.sv */
`timescale 1ns/1ns

module aluTb;

  typedef struct packed {
    aluPkg::aluOp                 op;
    logic [aluPkg::dataWidth-1:0] a;
    logic [aluPkg::dataWidth-1:0] b;
    logic [aluPkg::dataWidth-1:0] result;
    logic                         carry;
    logic                         overflow;
    logic                         zero;
  } testRow;

  localparam int creditTimeout = 200;
  localparam int drainTimeout = 300;
  localparam int holdCycles = 40;

  logic clk;
  logic reset;
  logic opValid;
  aluPkg::aluOp opCode;
  logic [aluPkg::dataWidth-1:0] opA;
  logic [aluPkg::dataWidth-1:0] opB;
  logic resCredit;
  logic opCredit;
  logic resValid;
  logic [aluPkg::dataWidth-1:0] resData;
  logic resCarry;
  logic resOverflow;
  logic resZero;
  logic [aluPkg::dataWidth-1:0] expResult;
  logic expCarry;
  logic expOverflow;
  logic expZero;
  int checkedCount;
  int failCount;

  testRow stimTable[$];
  int directedRows;
  int upCredits;
  int sentCount;
  int phaseStart;
  int tbErrors;
  int owed;
  int gapLeft;
  bit timedOut;
  bit holdCredits;
  bit randomGaps;

  aluUnit DUT (
    .clk         (clk),
    .reset       (reset),
    .opValid     (opValid),
    .opCode      (opCode),
    .opA         (opA),
    .opB         (opB),
    .resCredit   (resCredit),
    .opCredit    (opCredit),
    .resValid    (resValid),
    .resData     (resData),
    .resCarry    (resCarry),
    .resOverflow (resOverflow),
    .resZero     (resZero)
  );

  aluChecker checks (
    .clk          (clk),
    .reset        (reset),
    .opValid      (opValid),
    .opCode       (opCode),
    .expResult    (expResult),
    .expCarry     (expCarry),
    .expOverflow  (expOverflow),
    .expZero      (expZero),
    .resValid     (resValid),
    .resData      (resData),
    .resCarry     (resCarry),
    .resOverflow  (resOverflow),
    .resZero      (resZero),
    .checkedCount (checkedCount),
    .failCount    (failCount)
  );

  always #5 clk = ~clk;

  // reference model straight from the ALU rules
  function automatic testRow makeRow(input aluPkg::aluOp op,
                                     input logic [31:0] a, input logic [31:0] b);
    testRow row;
    logic [32:0] wide;
    row = '0;
    row.op = op;
    row.a = a;
    row.b = b;
    case (op)
      aluPkg::opAdd: begin
        wide = {1'b0, a} + {1'b0, b};
        row.result = wide[31:0];
        row.carry = wide[32];
        row.overflow = (a[31] == b[31]) && (row.result[31] != a[31]);
      end
      aluPkg::opSub: begin
        wide = {1'b0, a} + {1'b0, ~b} + 33'd1;
        row.result = wide[31:0];
        row.carry = wide[32];
        row.overflow = (a[31] != b[31]) && (row.result[31] != a[31]);
      end
      aluPkg::opXor:  row.result = a ^ b;
      aluPkg::opSlt:  row.result = {31'd0, $signed(a) < $signed(b)};
      aluPkg::opAnd:  row.result = a & b;
      aluPkg::opNand: row.result = ~(a & b);
      aluPkg::opNor:  row.result = ~(a | b);
      default:        row.result = a | b;
    endcase
    row.zero = (row.result == '0);
    return row;
  endfunction

  task automatic addRow(input aluPkg::aluOp op, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] res, input logic c, input logic v, input logic z);
    stimTable.push_back('{op, a, b, res, c, v, z});
  endtask

  task automatic buildTable();
    logic [31:0] a;
    logic [31:0] b;
    //     op              a             b             result        c     v     z
    addRow(aluPkg::opAdd,  32'h7fffffff, 32'h00000001, 32'h80000000, 1'b0, 1'b1, 1'b0);
    addRow(aluPkg::opAdd,  32'hffffffff, 32'h00000001, 32'h00000000, 1'b1, 1'b0, 1'b1);
    addRow(aluPkg::opAdd,  32'h80000000, 32'h80000000, 32'h00000000, 1'b1, 1'b1, 1'b1);
    addRow(aluPkg::opSub,  32'h00000000, 32'h00000001, 32'hffffffff, 1'b0, 1'b0, 1'b0);
    addRow(aluPkg::opSub,  32'h80000000, 32'h00000001, 32'h7fffffff, 1'b1, 1'b1, 1'b0);
    addRow(aluPkg::opSub,  32'h00000005, 32'h00000005, 32'h00000000, 1'b1, 1'b0, 1'b1);
    addRow(aluPkg::opXor,  32'hffffffff, 32'h0f0f0f0f, 32'hf0f0f0f0, 1'b0, 1'b0, 1'b0);
    addRow(aluPkg::opAnd,  32'h12345678, 32'hedcba987, 32'h00000000, 1'b0, 1'b0, 1'b1);
    addRow(aluPkg::opAnd,  32'hffffffff, 32'hffffffff, 32'hffffffff, 1'b0, 1'b0, 1'b0);
    addRow(aluPkg::opNand, 32'hffffffff, 32'hffffffff, 32'h00000000, 1'b0, 1'b0, 1'b1);
    addRow(aluPkg::opNor,  32'h00000000, 32'h00000000, 32'hffffffff, 1'b0, 1'b0, 1'b0);
    addRow(aluPkg::opNor,  32'h00000003, 32'h00000005, 32'hfffffff8, 1'b0, 1'b0, 1'b0);
    addRow(aluPkg::opOr,   32'h00000000, 32'h00000000, 32'h00000000, 1'b0, 1'b0, 1'b1);
    addRow(aluPkg::opOr,   32'hf0000000, 32'h0000000f, 32'hf000000f, 1'b0, 1'b0, 1'b0);
    addRow(aluPkg::opSlt,  32'hffffffff, 32'h00000001, 32'h00000001, 1'b0, 1'b0, 1'b0);
    addRow(aluPkg::opSlt,  32'h00000001, 32'hffffffff, 32'h00000000, 1'b0, 1'b0, 1'b1);
    addRow(aluPkg::opSlt,  32'h00000007, 32'h00000007, 32'h00000000, 1'b0, 1'b0, 1'b1);
    addRow(aluPkg::opSlt,  32'hfffffffe, 32'hffffffff, 32'h00000001, 1'b0, 1'b0, 1'b0);
    directedRows = stimTable.size();
    // back-pressure burst
    for (int i = 0; i < 10; i++) begin
      stimTable.push_back(makeRow(aluPkg::aluOp'(3'(i)), 32'(i * 7 + 3), 32'(i)));
    end
    // random mix, equal operands now and then for SLT and SUB
    for (int i = 0; i < 40; i++) begin
      a = $urandom;
      b = ($urandom_range(3, 0) == 0) ? a : $urandom;
      stimTable.push_back(makeRow(aluPkg::aluOp'(3'($urandom_range(7, 0))), a, b));
    end
  endtask

  // every driver step lands 1 ns after the edge and picks up returned credits
  task automatic stepCycle();
    @(posedge clk);
    #1;
    if (opCredit) upCredits++;
  endtask

  task automatic sendOp(input testRow row);
    int waited;
    waited = 0;
    while (!timedOut && upCredits == 0) begin
      stepCycle();
      waited++;
      if (waited > creditTimeout) begin
        $display("timeout: no operation credit came back in %0d cycles", creditTimeout);
        timedOut = 1'b1;
      end
    end
    if (timedOut) return;
    opValid = 1'b1;
    opCode = row.op;
    opA = row.a;
    opB = row.b;
    expResult = row.result;
    expCarry = row.carry;
    expOverflow = row.overflow;
    expZero = row.zero;
    upCredits--;
    sentCount++;
    stepCycle();
    opValid = 1'b0;
  endtask

  task automatic applyRange(input int first, input int last);
    for (int i = first; i < last; i++) begin
      sendOp(stimTable[i]);
    end
  endtask

  task automatic waitDrain();
    int waited;
    waited = 0;
    while (!timedOut && checkedCount != sentCount) begin
      stepCycle();
      waited++;
      if (waited > drainTimeout) begin
        $display("timeout: %0d results never came out", sentCount - checkedCount);
        timedOut = 1'b1;
      end
    end
    // let the last credits travel back
    repeat (4) stepCycle();
  endtask

  task automatic releaseCredits();
    repeat (holdCycles) @(posedge clk);
    #2;
    if (sentCount - phaseStart != aluPkg::queueDepth + aluPkg::resCredits) begin
      $display("CHECK FAILED acceptedOps: got %h expected %h", sentCount - phaseStart,
               aluPkg::queueDepth + aluPkg::resCredits);
      tbErrors++;
    end
    holdCredits = 1'b0;
  endtask

  task automatic finishRun();
    $display("sent %0d, checked %0d, failed %0d, other errors %0d",
             sentCount, checkedCount, failCount, tbErrors);
    if (!timedOut && failCount == 0 && tbErrors == 0 && checkedCount == sentCount) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  // downstream buffer, hands back one slot per result after an optional gap
  initial begin : downstream
    resCredit = 1'b0;
    owed = 0;
    gapLeft = 0;
    forever begin
      @(posedge clk);
      #1;
      resCredit = 1'b0;
      if (resValid && !reset) owed++;
      if (gapLeft > 0) begin
        gapLeft--;
      end else if (owed > 0 && !holdCredits) begin
        resCredit = 1'b1;
        owed--;
        gapLeft = randomGaps ? int'($urandom_range(4, 0)) : 0;
      end
    end
  end

  initial begin
    void'($urandom(69581));
    clk = 1'b0;
    reset = 1'b1;
    opValid = 1'b0;
    opCode = aluPkg::opAdd;
    opA = '0;
    opB = '0;
    expResult = '0;
    expCarry = 1'b0;
    expOverflow = 1'b0;
    expZero = 1'b0;
    upCredits = aluPkg::queueDepth;
    sentCount = 0;
    tbErrors = 0;
    timedOut = 1'b0;
    holdCredits = 1'b0;
    randomGaps = 1'b0;
    buildTable();
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    applyRange(0, directedRows);
    waitDrain();
    #2;
    holdCredits = 1'b1;
    phaseStart = sentCount;
    fork
      applyRange(directedRows, directedRows + 10);
      releaseCredits();
    join
    waitDrain();
    #2;
    randomGaps = 1'b1;
    applyRange(directedRows + 10, stimTable.size());
    waitDrain();
    finishRun();
  end

endmodule

/* sim/aluChecker.sv */
`timescale 1ns/1ns

module aluChecker (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          opValid,
  input  aluPkg::aluOp                  opCode,
  input  logic [aluPkg::dataWidth-1:0]  expResult,
  input  logic                          expCarry,
  input  logic                          expOverflow,
  input  logic                          expZero,
  input  logic                          resValid,
  input  logic [aluPkg::dataWidth-1:0]  resData,
  input  logic                          resCarry,
  input  logic                          resOverflow,
  input  logic                          resZero,
  output int                            checkedCount,
  output int                            failCount
);

  typedef struct packed {
    aluPkg::aluOp                 op;
    logic [aluPkg::dataWidth-1:0] result;
    logic                         carry;
    logic                         overflow;
    logic                         zero;
  } expEntry;

  // expected results in the order the ops were accepted
  expEntry pending[$];

  task automatic compareField(input string name, input logic [31:0] got,
                              input logic [31:0] want, inout bit bad);
    if (got !== want) begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, want);
      bad = 1'b1;
    end
  endtask

  always @(posedge clk) begin : checkBeat
    expEntry want;
    aluPkg::aluOp opName;
    bit bad;
    if (reset) begin
      pending.delete();
      checkedCount = 0;
      failCount = 0;
    end else begin
      if (resValid) begin
        checkedCount++;
        if (pending.size() == 0) begin
          $display("result %h arrived with no operation outstanding", resData);
          failCount++;
        end else begin
          want = pending.pop_front();
          opName = want.op;
          bad = 1'b0;
          compareField("resData", resData, want.result, bad);
          compareField("resCarry", 32'(resCarry), 32'(want.carry), bad);
          compareField("resOverflow", 32'(resOverflow), 32'(want.overflow), bad);
          compareField("resZero", 32'(resZero), 32'(want.zero), bad);
          $display("test %0d %s: %s", checkedCount, opName.name(), bad ? "mismatch" : "ok");
          if (bad) failCount++;
        end
      end
      if (opValid) begin
        pending.push_back('{opCode, expResult, expCarry, expOverflow, expZero});
      end
    end
  end

endmodule

/* sim/aluUnit_assert.sv */
`timescale 1ns/1ns

module aluUnitAssert (
  input logic                                clk,
  input logic                                reset,
  input logic                                opValid,
  input logic                                opCredit,
  input logic                                resValid,
  input logic                                resCredit,
  input logic [aluPkg::queueCountWidth-1:0]  queueCount,
  input logic [aluPkg::creditWidth-1:0]      creditCount
);

  // result slots still free downstream as seen from the ports
  int downCredits;

  always_ff @(posedge clk) begin
    if (reset) begin
      downCredits <= aluPkg::resCredits;
    end else begin
      downCredits <= downCredits - int'(resValid) + int'(resCredit);
    end
  end

  creditBound: assert property (@(posedge clk) disable iff (reset)
    creditCount <= aluPkg::creditInit)
    else $error("result credit count above the downstream buffer depth");

  // credits returned too early would let an op hit a full queue
  noOpWhenFull: assert property (@(posedge clk) disable iff (reset)
    opValid |-> queueCount != aluPkg::queueFull)
    else $error("operation sent while the input queue is full");

  noResultWithoutCredit: assert property (@(posedge clk) disable iff (reset)
    resValid |-> downCredits > 0)
    else $error("result sent without a downstream credit");

  quietAfterReset: assert property (@(posedge clk)
    reset |=> !resValid && !opCredit)
    else $error("resValid or opCredit high right after reset");

endmodule

bind aluUnit aluUnitAssert protocolChecks (
  .clk         (clk),
  .reset       (reset),
  .opValid     (opValid),
  .opCredit    (opCredit),
  .resValid    (resValid),
  .resCredit   (resCredit),
  .queueCount  (queueInst.count),
  .creditCount (senderInst.creditCount)
);

/* verilog/aluUnit.sv */
`timescale 1ns/1ns

module aluUnit (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          opValid,
  input  aluPkg::aluOp                  opCode,
  input  logic [aluPkg::dataWidth-1:0]  opA,
  input  logic [aluPkg::dataWidth-1:0]  opB,
  input  logic                          resCredit,
  output logic                          opCredit,
  output logic                          resValid,
  output logic [aluPkg::dataWidth-1:0]  resData,
  output logic                          resCarry,
  output logic                          resOverflow,
  output logic                          resZero
);

  logic                         headValid;
  aluPkg::aluOp                 headOp;
  logic [aluPkg::dataWidth-1:0] headA;
  logic [aluPkg::dataWidth-1:0] headB;
  logic                         pop;
  logic [aluPkg::dataWidth-1:0] coreResult;
  logic                         coreCarry;
  logic                         coreOverflow;
  logic                         coreZero;

  opQueue queueInst (
    .clk       (clk),
    .reset     (reset),
    .opValid   (opValid),
    .opCode    (opCode),
    .opA       (opA),
    .opB       (opB),
    .pop       (pop),
    .headValid (headValid),
    .headOp    (headOp),
    .headA     (headA),
    .headB     (headB),
    .opCredit  (opCredit)
  );

  // combinational from the queue head
  aluCore coreInst (
    .op       (headOp),
    .a        (headA),
    .b        (headB),
    .result   (coreResult),
    .carryOut (coreCarry),
    .overflow (coreOverflow),
    .zero     (coreZero)
  );

  resultSender senderInst (
    .clk          (clk),
    .reset        (reset),
    .headValid    (headValid),
    .coreResult   (coreResult),
    .coreCarry    (coreCarry),
    .coreOverflow (coreOverflow),
    .coreZero     (coreZero),
    .resCredit    (resCredit),
    .pop          (pop),
    .resValid     (resValid),
    .resData      (resData),
    .resCarry     (resCarry),
    .resOverflow  (resOverflow),
    .resZero      (resZero)
  );

endmodule

/* verilog/resultSender.sv */
`timescale 1ns/1ns

module resultSender (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          headValid,
  input  logic [aluPkg::dataWidth-1:0]  coreResult,
  input  logic                          coreCarry,
  input  logic                          coreOverflow,
  input  logic                          coreZero,
  input  logic                          resCredit,
  output logic                          pop,
  output logic                          resValid,
  output logic [aluPkg::dataWidth-1:0]  resData,
  output logic                          resCarry,
  output logic                          resOverflow,
  output logic                          resZero
);

  logic [aluPkg::creditWidth-1:0] creditCount;

  // send whenever there is work and a free downstream slot
  assign pop = headValid && (creditCount != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      creditCount <= aluPkg::creditInit;
      resValid    <= 1'b0;
    end else begin
      // spend and return can land in the same cycle
      case ({pop, resCredit})
        2'b10:   creditCount <= creditCount - 1'b1;
        2'b01:   creditCount <= creditCount + 1'b1;
        default: creditCount <= creditCount;
      endcase
      resValid <= pop;
    end
  end

  // result fields captured on the pop, valid the next cycle
  always_ff @(posedge clk) begin
    if (pop) begin
      resData     <= coreResult;
      resCarry    <= coreCarry;
      resOverflow <= coreOverflow;
      resZero     <= coreZero;
    end
  end

endmodule

/* verilog/opQueue.sv */
`timescale 1ns/1ns

module opQueue (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          opValid,
  input  aluPkg::aluOp                  opCode,
  input  logic [aluPkg::dataWidth-1:0]  opA,
  input  logic [aluPkg::dataWidth-1:0]  opB,
  input  logic                          pop,
  output logic                          headValid,
  output aluPkg::aluOp                  headOp,
  output logic [aluPkg::dataWidth-1:0]  headA,
  output logic [aluPkg::dataWidth-1:0]  headB,
  output logic                          opCredit
);

  aluPkg::aluOp                 opMem [aluPkg::queueDepth];
  logic [aluPkg::dataWidth-1:0] aMem  [aluPkg::queueDepth];
  logic [aluPkg::dataWidth-1:0] bMem  [aluPkg::queueDepth];
  logic [aluPkg::queuePtrWidth-1:0]   wrPtr;
  logic [aluPkg::queuePtrWidth-1:0]   rdPtr;
  logic [aluPkg::queueCountWidth-1:0] count;
  logic push;

  // a full queue never takes a write, so no entry gets overwritten
  assign push = opValid && (count != aluPkg::queueFull);

  always_ff @(posedge clk) begin
    if (push) begin
      opMem[wrPtr] <= opCode;
      aMem[wrPtr]  <= opA;
      bMem[wrPtr]  <= opB;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      opCredit <= 1'b0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == aluPkg::queueLast) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == aluPkg::queueLast) ? '0 : rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // one credit back to upstream for each entry freed
      opCredit <= pop;
    end
  end

  // head entry feeds the core directly
  assign headValid = (count != '0);
  assign headOp    = opMem[rdPtr];
  assign headA     = aMem[rdPtr];
  assign headB     = bMem[rdPtr];

endmodule

/* verilog/aluCore.sv */
`timescale 1ns/1ns

module aluCore (
  input  aluPkg::aluOp                  op,
  input  logic [aluPkg::dataWidth-1:0]  a,
  input  logic [aluPkg::dataWidth-1:0]  b,
  output logic [aluPkg::dataWidth-1:0]  result,
  output logic                          carryOut,
  output logic                          overflow,
  output logic                          zero
);

  logic [aluPkg::cmdWidth-1:0]  cmd;
  logic [aluPkg::dataWidth:0]   carry;
  logic [aluPkg::dataWidth-1:0] sliceResult;
  logic [aluPkg::dataWidth-1:0] lessChain;
  logic isAdd;
  logic isSub;
  logic isSlt;
  logic isArith;
  logic signDiffer;
  logic sltBit;

  // opcode to one-hot command
  always_comb begin
    cmd = '0;
    cmd[op] = 1'b1;
  end

  assign isAdd   = cmd[aluPkg::opAdd];
  assign isSub   = cmd[aluPkg::opSub];
  assign isSlt   = cmd[aluPkg::opSlt];
  assign isArith = isAdd | isSub;

  // SUB needs the +1 of two's complement
  // SLT seeds 1 so equal operands end the chain as a >= b
  assign carry[0] = isSub | isSlt;

  for (genvar i = 0; i < aluPkg::dataWidth; i++) begin : gSlice
    bitSlice slice (
      .a        (a[i]),
      .b        (b[i]),
      .carryIn  (carry[i]),
      .cmd      (cmd),
      .result   (sliceResult[i]),
      .carryOut (carry[i+1]),
      .lessOut  (lessChain[i])
    );
  end

  // top of the chain holds unsigned a >= b
  // with opposite signs the negative operand is the smaller one
  assign signDiffer = a[aluPkg::dataWidth-1] ^ b[aluPkg::dataWidth-1];
  assign sltBit = signDiffer ? a[aluPkg::dataWidth-1] : ~lessChain[aluPkg::dataWidth-1];

  assign result = {sliceResult[aluPkg::dataWidth-1:1], sliceResult[0] | (isSlt & sltBit)};

  // carry flag only reported for ADD and SUB, SLT reuses the chain
  assign carryOut = carry[aluPkg::dataWidth] & isArith;

  // signed overflow when carry into and out of the sign bit disagree
  assign overflow = isArith & (carry[aluPkg::dataWidth] ^ carry[aluPkg::dataWidth-1]);

  assign zero = ~|result;

endmodule

/* verilog/bitSlice.sv */
`timescale 1ns/1ns

module bitSlice (
  input  logic                         a,
  input  logic                         b,
  input  logic                         carryIn,
  input  logic [aluPkg::cmdWidth-1:0]  cmd,
  output logic                         result,
  output logic                         carryOut,
  output logic                         lessOut
);

  logic bInv;
  logic halfAdd;
  logic sumAdd;
  logic carryAdd;
  logic halfSub;
  logic sumSub;
  logic carrySub;
  logic [aluPkg::cmdWidth-1:0] results;
  logic [aluPkg::cmdWidth-1:0] carries;

  assign bInv = ~b;

  // full adder for ADD
  assign halfAdd  = a ^ b;
  assign sumAdd   = halfAdd ^ carryIn;
  assign carryAdd = (a & b) | (halfAdd & carryIn);

  // same adder on inverted b, the core seeds the chain with 1 for SUB
  assign halfSub  = a ^ bInv;
  assign sumSub   = halfSub ^ carryIn;
  assign carrySub = (a & bInv) | (halfSub & carryIn);

  // compare stage
  // a above b at this bit wins, equal bits pass the lower verdict up
  assign lessOut = (a & bInv) | (~halfAdd & carryIn);

  // candidates in command-bit order, SLT bit stays 0 here
  assign results = {
    a | b,
    ~(a | b),
    ~(a & b),
    a & b,
    1'b0,
    halfAdd,
    sumSub,
    sumAdd
  };

  // only the arithmetic ops and the compare chain carry anything upward
  assign carries = {4'b0000, lessOut, 1'b0, carrySub, carryAdd};

  // and-or select with the one-hot command
  assign result   = |(results & cmd);
  assign carryOut = |(carries & cmd);

endmodule

/* verilog/aluPkg.sv */
package aluPkg;

  // operand and result width
  localparam int dataWidth = 32;

  // one-hot command word that every slice receives
  localparam int cmdWidth = 8;

  // opcodes in slice command-bit order, so the one-hot word is bit op set
  typedef enum logic [2:0] {
    opAdd  = 3'd0,
    opSub  = 3'd1,
    opXor  = 3'd2,
    opSlt  = 3'd3,
    opAnd  = 3'd4,
    opNand = 3'd5,
    opNor  = 3'd6,
    opOr   = 3'd7
  } aluOp;

  // input queue entries, also the credits upstream holds after reset
  localparam int queueDepth = 4;
  localparam int queuePtrWidth = $clog2(queueDepth);
  localparam int queueCountWidth = $clog2(queueDepth + 1);
  localparam logic [queuePtrWidth-1:0] queueLast = queuePtrWidth'(queueDepth - 1);
  localparam logic [queueCountWidth-1:0] queueFull = queueCountWidth'(queueDepth);

  // downstream buffer slots, the result sender starts with this many credits
  localparam int resCredits = 2;
  localparam int creditWidth = $clog2(resCredits + 1);
  localparam logic [creditWidth-1:0] creditInit = creditWidth'(resCredits);

endpackage
